// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and register file
`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_NUM_REGS    32

// Opcode field values
`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDI     6'h08
`define CPU_OP_ANDI     6'h0C
`define CPU_OP_ORI      6'h0D
`define CPU_OP_LUI      6'h0F

// Function field values for R-type
`define CPU_FN_ADD      6'h20
`define CPU_FN_SUB      6'h22
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_XOR      6'h26
`define CPU_FN_SLT      6'h2A
`define CPU_FN_SLL      6'h00
`define CPU_FN_SRL      6'h02

`endif

// File: cpuPkg.sv
`include "cpu_params.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0]   wordT;
    typedef logic [`CPU_REG_AW-1:0] regAddrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui
    } aluOpE;

    // Register format
    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    // Immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        regAddrT     rs;
        regAddrT     rt;
        logic [15:0] imm;
    } iFieldsT;

    typedef union packed {
        rFieldsT r;
        iFieldsT i;
    } instrU;

endpackage

// File: instrDecode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module instrDecode (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  cpuPkg::wordT     instr,
    input  cpuPkg::wordT     rdDataA,
    input  cpuPkg::wordT     rdDataB,
    output cpuPkg::regAddrT  rdAddrA,
    output cpuPkg::regAddrT  rdAddrB,
    output logic             exValid,
    output cpuPkg::aluOpE    aluOp,
    output cpuPkg::wordT     opA,
    output cpuPkg::wordT     opB,
    output cpuPkg::wordT     imm,
    output logic             useImm,
    output logic [4:0]       shamt,
    output cpuPkg::regAddrT  rsAddr,
    output cpuPkg::regAddrT  rtAddr,
    output cpuPkg::regAddrT  dstReg,
    output logic             dstWrite
);
    import cpuPkg::*;

    instrU   instrReg;
    logic    decValid;

    aluOpE   aluOpNext;
    wordT    immNext;
    logic    useImmNext;
    logic    supported;
    regAddrT srcA;
    regAddrT srcB;
    regAddrT dstNext;

    // Decode register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid;
        end
        if (instrValid) begin
            instrReg <= instr;
        end
    end

    // Field decode and control
    always_comb begin
        aluOpNext  = aluAdd;
        immNext    = '0;
        useImmNext = 1'b0;
        supported  = 1'b1;
        srcA       = instrReg.i.rs;
        srcB       = instrReg.i.rt;
        dstNext    = instrReg.i.rt;
        case (instrReg.r.opcode)
            `CPU_OP_RTYPE: begin
                srcA    = instrReg.r.rs;
                srcB    = instrReg.r.rt;
                dstNext = instrReg.r.rd;
                case (instrReg.r.funct)
                    `CPU_FN_ADD: aluOpNext = aluAdd;
                    `CPU_FN_SUB: aluOpNext = aluSub;
                    `CPU_FN_AND: aluOpNext = aluAnd;
                    `CPU_FN_OR:  aluOpNext = aluOr;
                    `CPU_FN_XOR: aluOpNext = aluXor;
                    `CPU_FN_SLT: aluOpNext = aluSlt;
                    `CPU_FN_SLL: aluOpNext = aluSll;
                    `CPU_FN_SRL: aluOpNext = aluSrl;
                    default:     supported = 1'b0;
                endcase
            end
            `CPU_OP_ADDI: begin
                aluOpNext  = aluAdd;
                useImmNext = 1'b1;
                immNext    = {{(`CPU_XLEN-16){instrReg.i.imm[15]}}, instrReg.i.imm};
            end
            `CPU_OP_ANDI: begin
                aluOpNext  = aluAnd;
                useImmNext = 1'b1;
                immNext    = {{(`CPU_XLEN-16){1'b0}}, instrReg.i.imm};
            end
            `CPU_OP_ORI: begin
                aluOpNext  = aluOr;
                useImmNext = 1'b1;
                immNext    = {{(`CPU_XLEN-16){1'b0}}, instrReg.i.imm};
            end
            `CPU_OP_LUI: begin
                aluOpNext  = aluLui;
                useImmNext = 1'b1;
                immNext    = {instrReg.i.imm, {(`CPU_XLEN-16){1'b0}}};
            end
            default: supported = 1'b0;
        endcase
    end

    assign rdAddrA = srcA;
    assign rdAddrB = srcB;

    // Execute register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid  <= 1'b0;
            dstWrite <= 1'b0;
        end else begin
            exValid  <= decValid;
            dstWrite <= decValid && supported && (dstNext != '0);
        end
        aluOp  <= aluOpNext;
        opA    <= rdDataA;
        opB    <= rdDataB;
        imm    <= immNext;
        useImm <= useImmNext;
        shamt  <= instrReg.r.shamt;
        rsAddr <= srcA;
        rtAddr <= srcB;
        dstReg <= dstNext;
    end

endmodule

// File: execStage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module execStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exValid,
    input  cpuPkg::aluOpE    aluOp,
    input  cpuPkg::wordT     opA,
    input  cpuPkg::wordT     opB,
    input  cpuPkg::wordT     imm,
    input  logic             useImm,
    input  logic [4:0]       shamt,
    input  cpuPkg::regAddrT  rsAddr,
    input  cpuPkg::regAddrT  rtAddr,
    input  cpuPkg::regAddrT  dstReg,
    input  logic             dstWrite,
    input  logic             fwdValid,
    input  cpuPkg::regAddrT  fwdReg,
    input  cpuPkg::wordT     fwdData,
    output logic             resValid,
    output cpuPkg::wordT     resData,
    output cpuPkg::regAddrT  resReg,
    output logic             resWrite
);
    import cpuPkg::*;

    logic fwdA;
    logic fwdB;
    wordT srcA;
    wordT srcRt;
    wordT srcB;
    wordT aluOut;

    // Result register overrides the stale register file value
    assign fwdA  = fwdValid && (fwdReg == rsAddr);
    assign fwdB  = fwdValid && (fwdReg == rtAddr);
    assign srcA  = fwdA ? fwdData : opA;
    assign srcRt = fwdB ? fwdData : opB;
    assign srcB  = useImm ? imm : srcRt;

    always_comb begin
        case (aluOp)
            aluAdd:  aluOut = srcA + srcB;
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluSlt:  aluOut = {{(`CPU_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            // Shifts operate on rt
            aluSll:  aluOut = srcB << shamt;
            aluSrl:  aluOut = srcB >> shamt;
            aluLui:  aluOut = srcB;
            default: aluOut = '0;
        endcase
    end

    // Result register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
            resWrite <= 1'b0;
        end else begin
            resValid <= exValid;
            resWrite <= exValid && dstWrite;
        end
        resData <= aluOut;
        resReg  <= dstReg;
    end

endmodule

// File: resultStage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module resultStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             resValid,
    input  cpuPkg::wordT     resData,
    input  cpuPkg::regAddrT  resReg,
    input  logic             resWrite,
    input  cpuPkg::regAddrT  rdAddrA,
    input  cpuPkg::regAddrT  rdAddrB,
    output cpuPkg::wordT     rdDataA,
    output cpuPkg::wordT     rdDataB,
    output logic             fwdValid,
    output cpuPkg::regAddrT  fwdReg,
    output cpuPkg::wordT     fwdData,
    output logic             wbValid,
    output cpuPkg::regAddrT  wbReg,
    output cpuPkg::wordT     wbData
);
    import cpuPkg::*;

    wordT regFile [`CPU_NUM_REGS];
    logic retire;

    // Only a valid, writing instruction retires
    assign retire = resValid && resWrite;

    assign fwdValid = retire;
    assign fwdReg   = resReg;
    assign fwdData  = resData;

    assign wbValid = retire;
    assign wbReg   = resReg;
    assign wbData  = resData;

    // Architectural register state
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (retire && (resReg != '0)) begin
            regFile[resReg] <= resData;
        end
    end

    // Write-through read ports
    always_comb begin
        if (rdAddrA == '0) begin
            rdDataA = '0;
        end else if (retire && (resReg == rdAddrA)) begin
            rdDataA = resData;
        end else begin
            rdDataA = regFile[rdAddrA];
        end
    end

    always_comb begin
        if (rdAddrB == '0) begin
            rdDataB = '0;
        end else if (retire && (resReg == rdAddrB)) begin
            rdDataB = resData;
        end else begin
            rdDataB = regFile[rdAddrB];
        end
    end

endmodule

// File: pipeCpu.sv
`timescale 1ns/1ps

module pipeCpu (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  cpuPkg::instrU    instr,
    output logic             wbValid,
    output cpuPkg::regAddrT  wbReg,
    output cpuPkg::wordT     wbData
);
    import cpuPkg::*;

    // Register file read
    regAddrT rdAddrA;
    regAddrT rdAddrB;
    wordT    rdDataA;
    wordT    rdDataB;

    // Decode to execute
    logic    exValid;
    aluOpE   aluOp;
    wordT    opA;
    wordT    opB;
    wordT    imm;
    logic    useImm;
    logic [4:0] shamt;
    regAddrT rsAddr;
    regAddrT rtAddr;
    regAddrT dstReg;
    logic    dstWrite;

    // Execute to result, and the bypass back
    logic    resValid;
    wordT    resData;
    regAddrT resReg;
    logic    resWrite;
    logic    fwdValid;
    regAddrT fwdReg;
    wordT    fwdData;

    instrDecode decode (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .exValid    (exValid),
        .aluOp      (aluOp),
        .opA        (opA),
        .opB        (opB),
        .imm        (imm),
        .useImm     (useImm),
        .shamt      (shamt),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .dstReg     (dstReg),
        .dstWrite   (dstWrite)
    );

    execStage exec (
        .clk        (clk),
        .rstN       (rstN),
        .exValid    (exValid),
        .aluOp      (aluOp),
        .opA        (opA),
        .opB        (opB),
        .imm        (imm),
        .useImm     (useImm),
        .shamt      (shamt),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .dstReg     (dstReg),
        .dstWrite   (dstWrite),
        .fwdValid   (fwdValid),
        .fwdReg     (fwdReg),
        .fwdData    (fwdData),
        .resValid   (resValid),
        .resData    (resData),
        .resReg     (resReg),
        .resWrite   (resWrite)
    );

    resultStage result (
        .clk        (clk),
        .rstN       (rstN),
        .resValid   (resValid),
        .resData    (resData),
        .resReg     (resReg),
        .resWrite   (resWrite),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .fwdValid   (fwdValid),
        .fwdReg     (fwdReg),
        .fwdData    (fwdData),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

endmodule

// File: pipeCpu_sva.sv
`timescale 1ns/1ps

module pipeCpuSva (
    input logic            clk,
    input logic            rstN,
    input logic            wbValid,
    input cpuPkg::regAddrT wbReg,
    input cpuPkg::wordT    wbData
);
    int failCount = 0;

    // Writeback port idle right after reset
    resetIdle: assert property (@(posedge clk) !rstN |=> !wbValid)
        else begin
            failCount++;
            $error("wbValid high in the cycle after reset");
        end

    // r0 is never a retiring destination
    noZeroDest: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbReg != '0)
        else begin
            failCount++;
            $error("writeback to register 0");
        end

    knownData: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> !$isunknown(wbData))
        else begin
            failCount++;
            $error("unknown writeback data");
        end

endmodule

bind pipeCpu pipeCpuSva sva (
    .clk     (clk),
    .rstN    (rstN),
    .wbValid (wbValid),
    .wbReg   (wbReg),
    .wbData  (wbData)
);

// File: pipeCpu_tb.sv
`timescale 1ns/1ps

module pipeCpuTb;
    import cpuPkg::*;

    localparam int MaxVectors   = 64;
    localparam int DrainTimeout = 10;

    logic    clk;
    logic    rstN;
    logic    instrValid;
    wordT    instr;
    logic    wbValid;
    regAddrT wbReg;
    wordT    wbData;

    // Four words per vector as instruction, writeback flag, register and data
    logic [31:0] vecMem [0:4*MaxVectors-1];
    int          numVectors;
    int          edgeCount;

    // Pending writebacks with the oldest first
    regAddrT expReg [$];
    wordT    expData [$];
    int      expEdge [$];

    pipeCpu dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Writeback port against the oldest pending entry
    task automatic checkWriteback();
        if (wbValid) begin
            assert (expReg.size() != 0)
                else abortRun($sformatf("writeback to r%0d at %t with none pending", wbReg, $time));
            assert (expEdge[0] == edgeCount)
                else abortRun($sformatf("writeback to r%0d at %t is %0d cycles off its slot",
                    wbReg, $time, edgeCount - expEdge[0]));
            assert (wbReg == expReg[0] && wbData == expData[0])
                else abortRun($sformatf("mismatch at %t: got r%0d = %h, expected r%0d = %h",
                    $time, wbReg, wbData, expReg[0], expData[0]));
            void'(expReg.pop_front());
            void'(expData.pop_front());
            void'(expEdge.pop_front());
        end else if (expEdge.size() != 0) begin
            assert (expEdge[0] > edgeCount)
                else abortRun($sformatf("no writeback to r%0d at %t although one was due",
                    expReg[0], $time));
        end
    endtask

    // Called 1 ns after a rising edge and returns 1 ns after the next one
    task automatic runCycle(input logic valid, input wordT word);
        instrValid = valid;
        instr      = word;
        @(negedge clk);
        checkWriteback();
        @(posedge clk);
        edgeCount++;
        #1;
    endtask

    task automatic applyReset();
        rstN       = 1'b0;
        instrValid = 1'b0;
        repeat (2) begin
            @(posedge clk);
            edgeCount++;
        end
        #1;
        rstN = 1'b1;
    endtask

    task automatic loadVectors();
        $readmemh("pipeCpu_vectors.txt", vecMem);
        numVectors = 0;
        while (numVectors < MaxVectors && vecMem[4*numVectors+1] != 32'h2) begin
            numVectors++;
        end
        assert (numVectors > 0 && numVectors < MaxVectors)
            else abortRun("vector file is empty or has no end marker");
    endtask

    // Issue every vector with optional 0 to 2 idle cycles after each
    task automatic runProgram(input logic withGaps);
        int idle;
        for (int n = 0; n < numVectors; n++) begin
            if (vecMem[4*n+1][0]) begin
                expReg.push_back(vecMem[4*n+2][4:0]);
                expData.push_back(vecMem[4*n+3]);
                // Sampled at the next edge and visible two edges later
                expEdge.push_back(edgeCount + 3);
            end
            runCycle(1'b1, vecMem[4*n]);
            if (withGaps) begin
                idle = $urandom % 3;
                repeat (idle) runCycle(1'b0, $urandom);
            end
        end
    endtask

    task automatic drainWritebacks();
        int waited;
        waited = 0;
        while (expReg.size() != 0) begin
            assert (waited < DrainTimeout)
                else abortRun("timed out waiting for the remaining writebacks");
            runCycle(1'b0, '0);
            waited++;
        end
    endtask

    initial begin
        void'($urandom(23));
        $timeformat(-9, 0, " ns", 0);
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        edgeCount  = 0;
        loadVectors();

        // Back-to-back issue sends every dependency through a bypass
        applyReset();
        repeat (4) runCycle(1'b0, '0);
        runProgram(1'b0);
        drainWritebacks();

        // Fresh register file and random idle gaps
        applyReset();
        repeat (4) runCycle(1'b0, '0);
        runProgram(1'b1);
        drainWritebacks();
        repeat (4) runCycle(1'b0, '0);

        if (dut.sva.failCount != 0) begin
            abortRun("bound assertions failed during the run");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: pipeCpu_vectors.txt
// instruction  writeback flag (0 none, 1 expected, 2 end of list)  register  data
// Expected values assume all registers start at zero
00430820 1 01 00000000
20010005 1 01 00000005
2002fffd 1 02 fffffffd
00221820 1 03 00000002
00222022 1 04 00000008
00412822 1 05 fffffff8
3406f0f0 1 06 0000f0f0
30478ff7 1 07 00008ff5
3c081234 1 08 12340000
35085678 1 08 12345678
01064824 1 09 00005070
01065025 1 0a 1234f6f8
01065826 1 0b 1234a688
0041602a 1 0c 00000001
0022682a 1 0d 00000000
00017100 1 0e 00000050
00027a02 1 0f 00ffffff
00210020 0 00 00000000
20007777 0 00 00000000
fc10ffff 0 00 00000000
00221821 0 00 00000000
00038020 1 10 00000002
02108820 1 11 00000004
02209022 1 12 00000004
2213ffff 1 13 00000001
0232a026 1 14 00000000
36958000 1 15 00008000
3c178000 1 17 80000000
02f3b02a 1 16 00000001
0017c7c2 1 18 00000001
0013cfc0 1 19 80000000
0339d020 1 1a 00000000
00000000 2 00 00000000

// File: vlog.f
+incdir+.
cpuPkg.sv
instrDecode.sv
execStage.sv
resultStage.sv
pipeCpu.sv
pipeCpu_sva.sv
pipeCpu_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module pipeCpuTb -Mdir obj_dir
	./obj_dir/VpipeCpuTb | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
